/* list.f */
source/board_ctrl_pkg.sv
source/key_debouncer.sv
source/heartbeat_led.sv
source/apb_ctrl_regs.sv
source/reset_pulse_stretcher.sv
source/reset_request_sink.sv
source/board_ctrl_top.sv
tests/board_ctrl_checker.sv
tests/board_ctrl_tb.sv

/* source/apb_ctrl_regs.sv */
// zero-wait-state apb slave holding the led, reset-request and status registers of the block
`default_nettype none

module apb_ctrl_regs (
	input  wire logic                                    fpga_clk_50,
	input  wire logic                                    hps_fpga_reset_n,
	input  wire board_ctrl_pkg::apb_req_t                apb_req,
	output board_ctrl_pkg::apb_rsp_t                     apb_rsp,
	input  wire logic [board_ctrl_pkg::key_count-1:0]    pressed,
	input  wire logic [board_ctrl_pkg::sw_count-1:0]     sw,
	input  wire logic                                    beat,
	input  wire board_ctrl_pkg::reset_vec_t              seen,        // sticky flags from sink
	output logic [board_ctrl_pkg::host_led_count-1:0]    host_led,
	output board_ctrl_pkg::reset_vec_t                   reset_level, // to stretchers
	output board_ctrl_pkg::reset_vec_t                   seen_clear   // w1c mask, one cycle
);

	import board_ctrl_pkg::*;

	reg_addr_e             addr;
	logic                  access;    // second apb phase
	logic                  addr_hit;  // address is mapped
	logic                  wr_en;
	logic [apb_data_w-1:0] rdata;

	assign addr   = reg_addr_e'(apb_req.paddr);
	assign access = apb_req.psel && apb_req.penable;
	assign wr_en  = access && apb_req.pwrite && addr_hit;  // unmapped writes dropped

	// ==================================================
	// address decode and read mux
	// ==================================================
	always_comb
	begin
		rdata    = '0;
		addr_hit = 1'b1;
		case (addr)
			reg_status:
			begin
				rdata[0]                               = beat;
				rdata[key_count:1]                     = pressed;
				rdata[key_count+sw_count:key_count+1]  = sw;
			end
			reg_led:        rdata[host_led_count-1:0] = host_led;
			reg_reset_req:  rdata[reset_lanes-1:0]    = reset_level;
			reg_reset_seen: rdata[reset_lanes-1:0]    = seen;
			default:        addr_hit = 1'b0;  // hole in the map
		endcase
	end

	always_comb
	begin
		apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
		apb_rsp.pready  = 1'b1;  // never stalls
		apb_rsp.pslverr = access && !addr_hit;
	end

	// clear mask goes straight to the sink, lands on the same edge as the write
	assign seen_clear = (wr_en && addr == reg_reset_seen) ? apb_req.pwdata[reset_lanes-1:0] : '0;

	// ==================================================
	// writable registers
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			host_led    <= '0;
			reset_level <= '0;
		end
		else
		begin
			if (wr_en && addr == reg_led)
				host_led <= apb_req.pwdata[host_led_count-1:0];
			if (wr_en && addr == reg_reset_req)
				reset_level <= apb_req.pwdata[reset_lanes-1:0];  // rise starts a pulse
		end
	end

endmodule

`default_nettype wire

/* source/board_ctrl_pkg.sv */
// shared widths, bus structs, lane and register enums for the board control block
`default_nettype none

package board_ctrl_pkg;

	// ==================================================
	// widths and counts
	// ==================================================
	localparam int apb_addr_w     = 4;
	localparam int apb_data_w     = 32;
	localparam int key_count      = 2;     // active-low push keys
	localparam int sw_count       = 4;     // slide switches
	localparam int host_led_count = 7;     // led[7:1], led[0] is heartbeat
	localparam int reset_lanes    = 3;

	// pulse length per lane, index = reset_lane_e
	localparam logic [reset_lanes-1:0][5:0] pulse_ext_table = {6'd32, 6'd2, 6'd6};

	// timing defaults at 50 MHz
	localparam int debounce_cycles_default = 50000;     // 1 ms
	localparam int heartbeat_half_default  = 25000000;  // 0.5 s

	// ==================================================
	// enums and bus types
	// ==================================================
	typedef enum logic [1:0] {lane_cold = 2'd0, lane_warm = 2'd1, lane_debug = 2'd2} reset_lane_e;

	typedef enum logic [apb_addr_w-1:0] {
		reg_status     = 4'h0,  // ro
		reg_led        = 4'h4,  // rw
		reg_reset_req  = 4'h8,  // rw, request levels
		reg_reset_seen = 4'hc   // ro, w1c
	} reg_addr_e;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [apb_addr_w-1:0] paddr;
		logic [apb_data_w-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [apb_data_w-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

	typedef logic [reset_lanes-1:0] reset_vec_t;  // one bit per lane

endpackage

`default_nettype wire

/* source/board_ctrl_top.sv */
// top of the board control block, wiring keys, heartbeat, apb registers and reset lanes
`default_nettype none

module board_ctrl_top #(
	parameter int debounce_cycles = board_ctrl_pkg::debounce_cycles_default,
	parameter int heartbeat_half  = board_ctrl_pkg::heartbeat_half_default
) (
	input  wire logic                                  fpga_clk_50,
	input  wire logic                                  hps_fpga_reset_n,
	input  wire board_ctrl_pkg::apb_req_t              apb_req,
	output board_ctrl_pkg::apb_rsp_t                   apb_rsp,
	input  wire logic [board_ctrl_pkg::key_count-1:0]  key,          // active low
	input  wire logic [board_ctrl_pkg::sw_count-1:0]   sw,
	output logic [board_ctrl_pkg::host_led_count:0]    led,          // [0] heartbeat
	output board_ctrl_pkg::reset_vec_t                 reset_req_n   // cold, warm, debug
);

	import board_ctrl_pkg::*;

	logic [key_count-1:0]      pressed;
	logic                      beat;
	logic [host_led_count-1:0] host_led;
	reset_vec_t                reset_level;  // regs to stretchers
	reset_vec_t                seen_clear;
	reset_vec_t                seen;
	reset_vec_t                pulse;        // stretchers to sink

	assign led = {host_led, beat};

	key_debouncer #(.debounce_cycles(debounce_cycles)) u_keys (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.key              (key),
		.pressed          (pressed)
	);

	heartbeat_led #(.heartbeat_half(heartbeat_half)) u_beat (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.beat             (beat)
	);

	apb_ctrl_regs u_regs (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.apb_req          (apb_req),
		.apb_rsp          (apb_rsp),
		.pressed          (pressed),
		.sw               (sw),
		.beat             (beat),
		.seen             (seen),
		.host_led         (host_led),
		.reset_level      (reset_level),
		.seen_clear       (seen_clear)
	);

	// ==================================================
	// one stretcher per reset lane
	// ==================================================
	for (genvar i = 0; i < reset_lanes; i++)
	begin : g_lane
		localparam reset_lane_e lane = reset_lane_e'(i);

		reset_pulse_stretcher #(.pulse_ext(int'(pulse_ext_table[lane]))) u_stretch (
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.level            (reset_level[lane]),
			.pulse            (pulse[lane])
		);
	end

	reset_request_sink u_sink (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.pulse            (pulse),
		.seen_clear       (seen_clear),
		.reset_req_n      (reset_req_n),
		.seen             (seen)
	);

endmodule

`default_nettype wire

/* source/heartbeat_led.sv */
// free-running divider that toggles the heartbeat led every heartbeat_half cycles
`default_nettype none

module heartbeat_led #(
	parameter int heartbeat_half = board_ctrl_pkg::heartbeat_half_default
) (
	input  wire logic fpga_clk_50,
	input  wire logic hps_fpga_reset_n,
	output logic      beat
);

	localparam int cnt_w = $clog2(heartbeat_half + 1);

	logic [cnt_w-1:0] cnt;  // cycles into the current half period

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			cnt  <= '0;
			beat <= 1'b0;  // led starts dark
		end
		else if (cnt == cnt_w'(heartbeat_half - 1))
		begin
			cnt  <= '0;     // wrap
			beat <= ~beat;  // toggle once per half period
		end
		else
			cnt <= cnt + 1'b1;
	end

endmodule

`default_nettype wire

/* source/key_debouncer.sv */
// debounces the active-low push keys into active-high pressed levels for the status register
`default_nettype none

module key_debouncer #(
	parameter int debounce_cycles = board_ctrl_pkg::debounce_cycles_default
) (
	input  wire logic                               fpga_clk_50,
	input  wire logic                               hps_fpga_reset_n,
	input  wire logic [board_ctrl_pkg::key_count-1:0] key,     // raw, active low
	output logic      [board_ctrl_pkg::key_count-1:0] pressed  // clean, active high
);

	import board_ctrl_pkg::*;

	localparam int cnt_w = $clog2(debounce_cycles + 1);

	logic [key_count-1:0] key_meta;   // first sync stage
	logic [key_count-1:0] key_sync;   // second sync stage
	logic [key_count-1:0] raw_pressed;
	logic [cnt_w-1:0]     cnt [key_count];  // cycles differing from pressed

	assign raw_pressed = ~key_sync;  // flip to active high

	// two-flop synchronizer, idles released
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			key_meta <= '1;
			key_sync <= '1;
		end
		else
		begin
			key_meta <= key;
			key_sync <= key_meta;
		end
	end

	// per key stability counter, any glitch back restarts it
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			pressed <= '0;
			for (int i = 0; i < key_count; i++)
				cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < key_count; i++)
			begin
				if (raw_pressed[i] == pressed[i])
					cnt[i] <= '0;                                  // agrees, nothing pending
				else if (cnt[i] == cnt_w'(debounce_cycles - 1))
				begin
					pressed[i] <= raw_pressed[i];                  // stable long enough
					cnt[i]     <= '0;
				end
				else
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/reset_pulse_stretcher.sv */
// turns the rise of one reset-request level into a pulse of pulse_ext cycles, one per lane
`default_nettype none

module reset_pulse_stretcher #(
	parameter int pulse_ext = int'(board_ctrl_pkg::pulse_ext_table[board_ctrl_pkg::lane_cold])
) (
	input  wire logic fpga_clk_50,
	input  wire logic hps_fpga_reset_n,
	input  wire logic level,   // request level from register
	output logic      pulse    // stretched, active high
);

	localparam int cnt_w = $clog2(pulse_ext + 1);

	logic             level_q;  // previous level
	logic             rise;
	logic [cnt_w-1:0] cnt;      // cycles of pulse left

	assign rise  = level && !level_q;
	assign pulse = (cnt != '0);  // high while counting down

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			level_q <= 1'b0;
		else
			level_q <= level;
	end

	// down-counter, a rise while busy is simply lost
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			cnt <= '0;
		else if (cnt != '0)
			cnt <= cnt - 1'b1;           // busy, keep counting
		else if (rise)
			cnt <= cnt_w'(pulse_ext);    // idle, start a new pulse
	end

endmodule

`default_nettype wire

/* source/reset_request_sink.sv */
// registers the lane pulses into active-low reset requests and keeps sticky seen flags
`default_nettype none

module reset_request_sink (
	input  wire logic                       fpga_clk_50,
	input  wire logic                       hps_fpga_reset_n,
	input  wire board_ctrl_pkg::reset_vec_t pulse,        // from stretchers
	input  wire board_ctrl_pkg::reset_vec_t seen_clear,   // w1c mask from regs
	output board_ctrl_pkg::reset_vec_t      reset_req_n,  // to processor, active low
	output board_ctrl_pkg::reset_vec_t      seen          // sticky, host readable
);

	// ==================================================
	// request outputs
	// ==================================================
	// one register stage, so requests trail the pulses by a cycle
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			reset_req_n <= '1;      // all idle
		else
			reset_req_n <= ~pulse;
	end

	// ==================================================
	// sticky flags
	// ==================================================
	// set beats clear when both hit one bit in the same cycle
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			seen <= '0;
		else
			seen <= (seen & ~seen_clear) | pulse;
	end

endmodule

`default_nettype wire

/* tests/board_ctrl_checker.sv */
// concurrent assertions on apb response and reset-request timing, bound into board_ctrl_top
`default_nettype none

module board_ctrl_checker (
	input wire logic                       fpga_clk_50,
	input wire logic                       hps_fpga_reset_n,
	input wire board_ctrl_pkg::apb_rsp_t   apb_rsp,
	input wire board_ctrl_pkg::reset_vec_t reset_req_n
);

	import board_ctrl_pkg::*;

	int assert_errors = 0;  // failed assertions so far

	// zero wait states, always ready
	ap_pready: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		apb_rsp.pready)
	else
	begin
		assert_errors++;
		$error("pready went low");
	end

	// no request right after reset release
	ap_quiet: assert property (@(posedge fpga_clk_50)
		$rose(hps_fpga_reset_n) |-> (reset_req_n == '1) [*4])
	else
	begin
		assert_errors++;
		$error("reset request active right after reset release");
	end

	// cold lane low for exactly its table length
	ap_cold: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		$fell(reset_req_n[lane_cold]) |->
			(!reset_req_n[lane_cold]) [*6] ##1 reset_req_n[lane_cold])
	else
	begin
		assert_errors++;
		$error("cold reset request not low for 6 cycles");
	end

endmodule

bind board_ctrl_top board_ctrl_checker u_checker (
	.fpga_clk_50      (fpga_clk_50),
	.hps_fpga_reset_n (hps_fpga_reset_n),
	.apb_rsp          (apb_rsp),
	.reset_req_n      (reset_req_n)
);

`default_nettype wire

/* tests/board_ctrl_tb.sv */
// testbench for board_ctrl_top, runs apb, reset-lane, key and heartbeat tests against a model
`default_nettype none

module board_ctrl_tb;

	import board_ctrl_pkg::*;

	localparam int clk_period     = 20;
	localparam int debounce_cyc   = 16;
	localparam int heartbeat_half = 50;
	localparam int test_cycles    = 640;  // rough sum of all test sections

	logic                    fpga_clk_50 = 1'b0;
	logic                    hps_fpga_reset_n;
	apb_req_t                apb_req;
	apb_rsp_t                apb_rsp;
	logic [key_count-1:0]    key;
	logic [sw_count-1:0]     sw;
	logic [host_led_count:0] led;
	reset_vec_t              reset_req_n;

	// ==================================================
	// model state
	// ==================================================
	logic [host_led_count-1:0] m_led;
	reset_vec_t                m_level;
	reset_vec_t                m_seen;
	logic [key_count-1:0]      m_pressed;
	int                        beat_cyc;  // edges since reset release
	integer                    seed;

	board_ctrl_top #(.debounce_cycles(debounce_cyc), .heartbeat_half(heartbeat_half)) dut0 (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.apb_req          (apb_req),
		.apb_rsp          (apb_rsp),
		.key              (key),
		.sw               (sw),
		.led              (led),
		.reset_req_n      (reset_req_n)
	);

	always #(clk_period / 2) fpga_clk_50 = ~fpga_clk_50;

	always @(posedge fpga_clk_50)
		beat_cyc <= hps_fpga_reset_n ? beat_cyc + 1 : 0;

	function automatic logic exp_beat();
		return ((beat_cyc / heartbeat_half) % 2) != 0;  // toggles each half period
	endfunction

	// expected {pslverr, prdata} for a read of addr
	function automatic logic [32:0] ref_read(input logic [3:0] addr);
		logic [31:0] data;
		logic        err;
		data = '0;
		err  = 1'b0;
		case (addr)
			4'h0: data[6:0] = {sw, m_pressed, exp_beat()};
			4'h4: data[6:0] = m_led;
			4'h8: data[2:0] = m_level;
			4'hc: data[2:0] = m_seen;
			default: err = 1'b1;  // unmapped
		endcase
		return {err, data};
	endfunction

	function automatic int pulse_len(input int lane);
		case (lane)
			0: return 6;   // cold
			1: return 2;   // warm
			default: return 32;  // debug
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	// setup cycle, access cycle, then idle
	task automatic bus_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata);
		@(posedge fpga_clk_50);
		#2;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge fpga_clk_50);
		#2;
		apb_req.penable = 1'b1;
		@(posedge fpga_clk_50);  // write lands here
		#2;
		apb_req = '0;
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		bus_access(1'b1, addr, data);
		case (addr)
			4'h4: m_led = data[6:0];
			4'h8: m_level = data[2:0];
			4'hc: m_seen = m_seen & ~data[2:0];  // w1c
			default: ;
		endcase
	endtask

	task automatic read_reg(input logic [3:0] addr);
		bus_access(1'b0, addr, 32'h0);
	endtask

	// called right after the write edge, checks delay and width of one lane
	task automatic measure_pulse(input int lane);
		int edges;
		int width;
		edges = 0;
		width = 0;
		while (reset_req_n[lane] && edges < 8)
		begin
			@(posedge fpga_clk_50);
			edges++;
			@(negedge fpga_clk_50);
		end
		check_value("reset_req_n start delay", edges, 2);
		m_seen[lane] = 1'b1;
		while (!reset_req_n[lane] && width < 64)
		begin
			width++;
			@(posedge fpga_clk_50);
			@(negedge fpga_clk_50);
		end
		check_value("reset_req_n low cycles", width, pulse_len(lane));
	endtask

	// ==================================================
	// compare process, mid-cycle where outputs are stable
	// ==================================================
	always @(negedge fpga_clk_50)
	begin : compare_outputs
		logic [32:0] exp_rsp;
		if (hps_fpga_reset_n)
		begin
			check_value("led[0]", led[0], exp_beat());
			check_value("led[7:1]", led[7:1], m_led);
			if (apb_req.psel && apb_req.penable)  // access cycle
			begin
				exp_rsp = ref_read(apb_req.paddr);
				check_value("pready", apb_rsp.pready, 1'b1);
				check_value("pslverr", apb_rsp.pslverr, exp_rsp[32]);
				if (!apb_req.pwrite)
					check_value("prdata", apb_rsp.prdata, exp_rsp[31:0]);
			end
		end
	end

	initial
	begin : stimulus
		logic [3:0]  addr;
		logic [31:0] data;
		logic        prev;
		int          n;
		seed             = 32'hdcde_763c;
		hps_fpga_reset_n = 1'b0;
		apb_req          = '0;
		key              = '1;  // released
		sw               = $random(seed);
		m_led            = '0;
		m_level          = '0;
		m_seen           = '0;
		m_pressed        = '0;
		repeat (4) @(posedge fpga_clk_50);
		#2 hps_fpga_reset_n = 1'b1;

		// state after reset
		check_value("reset_req_n", reset_req_n, 3'b111);
		read_reg(reg_status);
		read_reg(reg_led);
		read_reg(reg_reset_seen);
		read_reg(reg_reset_req);

		// led readback, switches, unmapped holes
		repeat (8)
		begin
			data = $random(seed);
			write_reg(reg_led, data);
			read_reg(reg_led);
		end
		@(posedge fpga_clk_50);
		#2 sw = $random(seed);
		read_reg(reg_status);
		repeat (4)
		begin
			addr = $random(seed);
			if (addr[1:0] == 2'b00)
				addr[0] = 1'b1;  // force a hole
			data = $random(seed);
			write_reg(addr, data);
			read_reg(addr);
			read_reg(reg_led);
			read_reg(reg_reset_req);
			read_reg(reg_reset_seen);
		end

		// each lane twice, clearing the level between pulses
		for (int lane = 0; lane < reset_lanes; lane++)
		begin
			repeat (2)
			begin
				write_reg(reg_reset_req, 32'h1 << lane);
				measure_pulse(lane);
				write_reg(reg_reset_req, 32'h0);
			end
		end

		// re-trigger in the middle of the debug pulse
		write_reg(reg_reset_req, 32'h4);
		fork
			measure_pulse(2);
			begin
				repeat (6) @(posedge fpga_clk_50);
				write_reg(reg_reset_req, 32'h0);
				write_reg(reg_reset_req, 32'h4);  // rise while busy
			end
		join
		repeat (40)
		begin
			@(negedge fpga_clk_50);
			check_value("reset_req_n", reset_req_n, 3'b111);  // no second pulse
		end
		write_reg(reg_reset_req, 32'h0);

		// sticky flags and w1c
		read_reg(reg_reset_seen);
		write_reg(reg_reset_seen, 32'h2);
		read_reg(reg_reset_seen);
		write_reg(reg_reset_seen, 32'h5);
		read_reg(reg_reset_seen);
		write_reg(reg_reset_req, 32'h2);
		measure_pulse(1);
		read_reg(reg_reset_seen);
		write_reg(reg_reset_req, 32'h0);
		write_reg(reg_reset_seen, $random(seed));
		read_reg(reg_reset_seen);

		// ==================================================
		// keys, short glitch then a real press
		// ==================================================
		@(posedge fpga_clk_50);
		#2 key[1] = 1'b0;
		repeat (2) @(posedge fpga_clk_50);
		read_reg(reg_status);  // mid glitch, still released
		key[1] = 1'b1;         // 5 cycles low in total
		repeat (30) @(posedge fpga_clk_50);
		read_reg(reg_status);  // glitch filtered
		key[0] = 1'b0;
		repeat (10) @(posedge fpga_clk_50);
		read_reg(reg_status);  // held, not debounced yet
		repeat (17) @(posedge fpga_clk_50);
		m_pressed[0] = 1'b1;
		read_reg(reg_status);
		key[0] = 1'b1;
		repeat (30) @(posedge fpga_clk_50);
		m_pressed[0] = 1'b0;
		read_reg(reg_status);

		// heartbeat spacing on led[0]
		n    = 0;
		prev = led[0];
		while (led[0] == prev && n < 60)
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		n    = 0;
		prev = led[0];
		while (led[0] == prev && n < 100)
		begin
			@(negedge fpga_clk_50);
			n++;
		end
		check_value("led[0] half period", n, heartbeat_half);

		if (dut0.u_checker.assert_errors != 0)
		begin
			$display("Assertion failures reported by the bound checker");
			$display("RESULT: FAIL");
			$fatal(1, "assertion failures");
		end
		else
		begin
			$display("RESULT: PASS");
			$finish;
		end
	end

	// watchdog, twice the expected run length
	initial
	begin
		#(test_cycles * 2 * clk_period);
		$display("Timeout: tests did not finish within %0d cycles", test_cycles * 2);
		$display("RESULT: FAIL");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire
